// File: src.f
frameDefs.sv
frameStore.sv
scanController.sv
pixelPacker.sv
frameDisplay.sv
tbFrameDisplay.sv

// File: tbFrameDisplay.sv
`timescale 1ns/1ps

module tbFrameDisplay;
   import frameDefs::*;

   localparam int TB_ADDR_WIDTH   = 8;
   localparam int TB_CREDITS      = 3;
   localparam int TB_FRAME_HOLD   = 2;
   localparam int PIXELS          = 2 ** TB_ADDR_WIDTH;
   localparam int BYTES_PER_FRAME = PIXELS / PACK_WIDTH;     // 32 bytes per frame
   localparam int CLK_HALF        = 20;                      // 40 ns period
   localparam int DRIVE_DELAY     = 2;                       // input skew after the edge
   localparam int PAUSE_POSITION  = 13;                      // byte in frame where scan drops

   logic                     clk;
   logic                     reset;
   logic                     scanEnable;
   logic                     creditReturn;
   logic                     loadEnable;
   logic                     loadFrame;
   logic [TB_ADDR_WIDTH-1:0] loadAddress;
   logic                     loadData;
   logic [PACK_WIDTH-1:0]    pixWord;
   logic                     pixValid;
   logic                     pixFirst;

   logic        imageBits [2][PIXELS];   // the two images held by the stores
   logic [31:0] rngState;
   int          byteCount;               // bytes seen so far, also the reference index
   int          returnCount;             // credits handed back
   int          errorCount;
   int          forceReturns;            // single returns asked for by the main flow
   logic        randomReturns;           // random return timing on/off
   logic        scanStarted;

   frameDisplay #(
      .ADDR_WIDTH(TB_ADDR_WIDTH),
      .CREDITS   (TB_CREDITS),
      .FRAME_HOLD(TB_FRAME_HOLD)
   ) dut_i (
      .clk         (clk),
      .reset       (reset),
      .scanEnable  (scanEnable),
      .creditReturn(creditReturn),
      .loadEnable  (loadEnable),
      .loadFrame   (loadFrame),
      .loadAddress (loadAddress),
      .loadData    (loadData),
      .pixWord     (pixWord),
      .pixValid    (pixValid),
      .pixFirst    (pixFirst)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // expected byte for a running index, first flag in bit 8
   function automatic logic [8:0] expectedByte(input int index);
      int         framePos;
      int         frameNum;
      int         k;
      logic [7:0] b;
      framePos = index % BYTES_PER_FRAME;
      frameNum = (index / BYTES_PER_FRAME / TB_FRAME_HOLD) % 2;  // alternate every hold
      for (k = 0; k < PACK_WIDTH; k++)
         b[k] = imageBits[frameNum][framePos * PACK_WIDTH + k];  // lowest address in bit 0
      return {framePos == 0, b};
   endfunction

   task automatic stepCycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic abortOnTimeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("checked %0d bytes, %0d errors", byteCount, errorCount + 1);
      $display("TB FAILED");
      $finish;
   endtask

   task automatic waitForBytes(input int target, input int limit, input string what);
      int n;
      n = 0;
      while (byteCount < target && n < limit) begin
         stepCycle();
         n++;
      end
      if (byteCount < target)
         abortOnTimeout(what);
   endtask

   task automatic waitForQuiet(input int quietNeeded, input int limit);
      int n;
      int quiet;
      int lastCount;
      n         = 0;
      quiet     = 0;
      lastCount = byteCount;
      while (quiet < quietNeeded && n < limit) begin
         stepCycle();
         n++;
         if (byteCount == lastCount) begin
            quiet++;
         end else begin
            quiet     = 0;
            lastCount = byteCount;
         end
      end
      if (quiet < quietNeeded)
         abortOnTimeout("the output to go quiet after scanEnable dropped");
   endtask

   // downstream side, hands back credits for bytes it has received
   initial begin
      creditReturn = 1'b0;
      forever begin
         stepCycle();
         if (forceReturns > 0) begin
            creditReturn = 1'b1;
            forceReturns--;
            returnCount++;
         end else if (randomReturns && (byteCount - returnCount) > 0) begin
            rngState = xorshift32(rngState);
            creditReturn = (rngState[4:0] < 5'd3);     // roughly one cycle in ten
            if (creditReturn)
               returnCount++;
         end else begin
            creditReturn = 1'b0;
         end
      end
   end

   // output checker
   always @(posedge clk) begin
      logic [8:0] expected;
      if (reset === 1'b0) begin
         if (pixValid === 1'b1) begin
            if (!scanStarted) begin
               errorCount++;
               $display("a byte came out before scanEnable was raised");
            end
            expected = expectedByte(byteCount);
            if (pixWord !== expected[7:0]) begin
               errorCount++;
               $display("error pixWord at byte %0d: got %h expected %h",
                        byteCount, pixWord, expected[7:0]);
            end
            if (pixFirst !== expected[8]) begin
               errorCount++;
               $display("error pixFirst at byte %0d: got %h expected %h",
                        byteCount, pixFirst, expected[8]);
            end
            byteCount++;
         end else if (pixValid !== 1'b0 || pixFirst !== 1'b0) begin
            errorCount++;
            $display("pixValid or pixFirst is unknown or pixFirst is high without a byte");
         end
      end
   end

   initial begin
      int f;
      int a;
      int heldCount;
      int n;
      reset         = 1'b1;
      scanEnable    = 1'b0;
      loadEnable    = 1'b0;
      loadFrame     = 1'b0;
      loadAddress   = '0;
      loadData      = 1'b0;
      rngState      = 32'd48354;
      byteCount     = 0;
      returnCount   = 0;
      errorCount    = 0;
      forceReturns  = 0;
      randomReturns = 1'b0;
      scanStarted   = 1'b0;

      for (f = 0; f < 2; f++) begin
         for (a = 0; a < PIXELS; a++) begin
            rngState = xorshift32(rngState);
            imageBits[f][a] = rngState[7];
         end
      end

      repeat (4) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      // load both images, scan stays off so nothing may come out
      for (f = 0; f < 2; f++) begin
         for (a = 0; a < PIXELS; a++) begin
            loadEnable  = 1'b1;
            loadFrame   = f[0];
            loadAddress = a[TB_ADDR_WIDTH-1:0];
            loadData    = imageBits[f][a];
            stepCycle();
         end
      end
      loadEnable = 1'b0;
      repeat (20) stepCycle();

      // credits withheld, only the initial grant may be used
      scanStarted = 1'b1;
      scanEnable  = 1'b1;
      waitForBytes(TB_CREDITS, 200, "the bytes of the initial credit grant");
      repeat (60) stepCycle();
      if (byteCount != TB_CREDITS) begin
         errorCount++;
         $display("error byteCount with credits withheld: got %h expected %h",
                  byteCount, TB_CREDITS);
      end

      forceReturns = 1;                         // exactly one credit back
      waitForBytes(TB_CREDITS + 1, 200, "the byte paid by a single credit");
      repeat (60) stepCycle();
      if (byteCount != TB_CREDITS + 1) begin
         errorCount++;
         $display("error byteCount after one credit return: got %h expected %h",
                  byteCount, TB_CREDITS + 1);
      end

      // random credit timing across several frames
      randomReturns = 1'b1;
      waitForBytes(3 * BYTES_PER_FRAME, 20000, "three frames under random credits");

      // drop scanEnable in the middle of a frame
      n = 0;
      while ((byteCount % BYTES_PER_FRAME) != PAUSE_POSITION && n < 2000) begin
         stepCycle();
         n++;
      end
      if ((byteCount % BYTES_PER_FRAME) != PAUSE_POSITION)
         abortOnTimeout("the mid-frame pause position");
      scanEnable = 1'b0;
      waitForQuiet(30, 1000);
      heldCount = byteCount;
      repeat (80) stepCycle();
      if (byteCount != heldCount) begin
         errorCount++;
         $display("bytes kept coming out while scanEnable was low");
      end

      scanEnable = 1'b1;                        // resumes at the next index
      waitForBytes(7 * BYTES_PER_FRAME, 30000, "seven frames in total");
      repeat (20) stepCycle();

      $display("checked %0d bytes, %0d errors", byteCount, errorCount);
      if (errorCount == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// File: frameDisplay.sv
`timescale 1ns/1ps

// two-frame monochrome display source
// scans the shown frame, packs pixels into bytes and sends them under credits
module frameDisplay #(
   parameter int ADDR_WIDTH = frameDefs::DEFAULT_ADDR_WIDTH,
   parameter int CREDITS    = frameDefs::DEFAULT_CREDITS,
   parameter int FRAME_HOLD = frameDefs::DEFAULT_FRAME_HOLD
) (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             scanEnable,
   input  logic                             creditReturn,
   input  logic                             loadEnable,
   input  logic                             loadFrame,     // store to write
   input  logic [ADDR_WIDTH-1:0]            loadAddress,
   input  logic                             loadData,
   output logic [frameDefs::PACK_WIDTH-1:0] pixWord,
   output logic                             pixValid,
   output logic                             pixFirst
);

   logic                  readEnable;
   logic [ADDR_WIDTH-1:0] readAddress;
   logic                  readFrame;
   logic                  groupFirst;
   logic [1:0]            storeRead;          // per-store read enable
   logic [1:0]            storeLoad;          // per-store load enable
   logic [1:0]            storeData;
   logic                  pixelValid;         // readEnable one cycle later
   logic                  frameMark;          // groupFirst one cycle later
   logic                  frameSelQ;          // readFrame one cycle later
   logic                  pixelBit;

   assign storeRead[0] = readEnable & ~readFrame;
   assign storeRead[1] = readEnable &  readFrame;
   assign storeLoad[0] = loadEnable & ~loadFrame;
   assign storeLoad[1] = loadEnable &  loadFrame;

   frameStore #(.ADDR_WIDTH(ADDR_WIDTH)) store0_i (
      .clk        (clk),
      .reset      (reset),
      .readEnable (storeRead[0]),
      .readAddress(readAddress),
      .loadEnable (storeLoad[0]),
      .loadAddress(loadAddress),
      .loadData   (loadData),
      .readData   (storeData[0])
   );

   frameStore #(.ADDR_WIDTH(ADDR_WIDTH)) store1_i (
      .clk        (clk),
      .reset      (reset),
      .readEnable (storeRead[1]),
      .readAddress(readAddress),
      .loadEnable (storeLoad[1]),
      .loadAddress(loadAddress),
      .loadData   (loadData),
      .readData   (storeData[1])
   );

   scanController #(
      .ADDR_WIDTH(ADDR_WIDTH),
      .CREDITS   (CREDITS),
      .FRAME_HOLD(FRAME_HOLD)
   ) scan_i (
      .clk         (clk),
      .reset       (reset),
      .scanEnable  (scanEnable),
      .creditReturn(creditReturn),
      .readEnable  (readEnable),
      .readAddress (readAddress),
      .readFrame   (readFrame),
      .groupFirst  (groupFirst)
   );

   // line the read controls up with the registered store output
   always_ff @(posedge clk) begin
      if (reset) begin
         pixelValid <= 1'b0;
         frameMark  <= 1'b0;
         frameSelQ  <= 1'b0;
      end else begin
         pixelValid <= readEnable;
         frameMark  <= groupFirst;
         frameSelQ  <= readFrame;
      end
   end

   assign pixelBit = frameSelQ ? storeData[1] : storeData[0];  // store that was read

   pixelPacker pack_i (
      .clk       (clk),
      .reset     (reset),
      .pixelBit  (pixelBit),
      .pixelValid(pixelValid),
      .frameMark (frameMark),
      .pixWord   (pixWord),
      .pixValid  (pixValid),
      .pixFirst  (pixFirst)
   );

endmodule

// File: pixelPacker.sv
`timescale 1ns/1ps

// packs eight consecutive pixels into one byte, lowest address in bit 0
module pixelPacker (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             pixelBit,
   input  logic                             pixelValid,
   input  logic                             frameMark,   // with the first pixel of a frame
   output logic [frameDefs::PACK_WIDTH-1:0] pixWord,
   output logic                             pixValid,    // one cycle per byte
   output logic                             pixFirst     // first byte of a frame
);
   import frameDefs::*;

   localparam int FILL_WIDTH = $clog2(PACK_WIDTH);
   localparam logic [FILL_WIDTH-1:0] LAST_FILL = FILL_WIDTH'(PACK_WIDTH - 1);

   logic [PACK_WIDTH-1:0] shiftWord;            // byte being assembled
   logic [PACK_WIDTH-1:0] nextWord;
   logic [FILL_WIDTH-1:0] fillCount;            // bits already in shiftWord
   logic                  firstFlag;
   logic                  wordDone;

   // new pixels enter at the top, so the oldest ends up in bit 0
   assign nextWord = {pixelBit, shiftWord[PACK_WIDTH-1:1]};
   assign wordDone = pixelValid && (fillCount == LAST_FILL);

   always_ff @(posedge clk) begin
      if (pixelValid)
         shiftWord <= nextWord;
      if (wordDone)
         pixWord <= nextWord;                   // freed shifter takes the next group
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fillCount <= '0;
         firstFlag <= 1'b0;
         pixValid  <= 1'b0;
         pixFirst  <= 1'b0;
      end else begin
         pixValid <= wordDone;
         pixFirst <= wordDone && (firstFlag || frameMark);
         if (pixelValid) begin
            fillCount <= fillCount + 1'b1;
            if (fillCount == '0)
               firstFlag <= frameMark;          // restart the flag for a new byte
            else
               firstFlag <= firstFlag || frameMark;
         end
      end
   end

endmodule

// File: scanController.sv
`timescale 1ns/1ps

// walks the displayed frame in address order, one pixel per cycle,
// in groups of eight reads that each cost one downstream byte credit
module scanController #(
   parameter int ADDR_WIDTH = frameDefs::DEFAULT_ADDR_WIDTH,
   parameter int CREDITS    = frameDefs::DEFAULT_CREDITS,
   parameter int FRAME_HOLD = frameDefs::DEFAULT_FRAME_HOLD
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  scanEnable,     // keep scanning while high
   input  logic                  creditReturn,   // one credit back per pulse
   output logic                  readEnable,
   output logic [ADDR_WIDTH-1:0] readAddress,
   output logic                  readFrame,      // 0 reads store 0, 1 reads store 1
   output logic                  groupFirst      // first read of a frame
);
   import frameDefs::*;

   localparam int BIT_WIDTH    = $clog2(PACK_WIDTH);
   localparam int CREDIT_WIDTH = $clog2(CREDITS + 1);
   localparam int REPEAT_WIDTH = (FRAME_HOLD > 1) ? $clog2(FRAME_HOLD) : 1;

   localparam logic [BIT_WIDTH-1:0]    LAST_BIT    = BIT_WIDTH'(PACK_WIDTH - 1);
   localparam logic [CREDIT_WIDTH-1:0] FULL_CREDIT = CREDIT_WIDTH'(CREDITS);
   localparam logic [REPEAT_WIDTH-1:0] LAST_REPEAT = REPEAT_WIDTH'(FRAME_HOLD - 1);

   scanStateT               state;
   scanStateT               nextState;
   logic [BIT_WIDTH-1:0]    bitCount;        // position inside the group
   logic [ADDR_WIDTH-1:0]   pixAddress;      // next pixel to read
   logic [CREDIT_WIDTH-1:0] creditCount;
   logic [REPEAT_WIDTH-1:0] repeatCount;     // frames shown from this store
   logic                    frameSel;
   logic                    groupEnd;
   logic                    frameEnd;
   logic                    haveCredit;
   logic                    startGroup;

   assign groupEnd   = (state == scanRun) && (bitCount == LAST_BIT);  // eighth read now
   assign frameEnd   = groupEnd && (pixAddress == '1);                // last pixel of frame
   assign haveCredit = (creditCount != '0);

   // a group may begin from idle/stall, or right behind the previous one
   assign startGroup = scanEnable && haveCredit &&
                       ((state != scanRun) || groupEnd);

   // next state
   always_comb begin
      nextState = state;
      case (state)
         scanIdle, scanStall: begin
            if (startGroup)
               nextState = scanRun;
            else if (scanEnable)
               nextState = scanStall;               // waiting for a credit
            else
               nextState = scanIdle;
         end
         scanRun: begin
            if (groupEnd) begin                     // only leave on a group boundary
               if (startGroup)
                  nextState = scanRun;
               else if (scanEnable)
                  nextState = scanStall;
               else
                  nextState = scanIdle;
            end
         end
         default: nextState = scanIdle;
      endcase
   end

   // state, group position and address
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= scanIdle;
         bitCount   <= '0;
         pixAddress <= '0;
      end else begin
         state <= nextState;
         if (state == scanRun) begin
            bitCount   <= bitCount + 1'b1;          // wraps after the eighth read
            pixAddress <= pixAddress + 1'b1;        // wraps at end of frame
         end
      end
   end

   // credit accounting
   always_ff @(posedge clk) begin
      if (reset) begin
         creditCount <= FULL_CREDIT;
      end else begin
         if (startGroup && !creditReturn)
            creditCount <= creditCount - 1'b1;
         else if (creditReturn && !startGroup && (creditCount != FULL_CREDIT))
            creditCount <= creditCount + 1'b1;      // never above the grant
      end
   end

   // frame repeat and alternation
   always_ff @(posedge clk) begin
      if (reset) begin
         repeatCount <= '0;
         frameSel    <= 1'b0;
      end else if (frameEnd) begin
         if (repeatCount == LAST_REPEAT) begin
            repeatCount <= '0;
            frameSel    <= ~frameSel;               // switch to the other store
         end else begin
            repeatCount <= repeatCount + 1'b1;
         end
      end
   end

   // read issue
   assign readEnable  = (state == scanRun);
   assign readAddress = pixAddress;
   assign readFrame   = frameSel;
   assign groupFirst  = readEnable && (pixAddress == '0);

endmodule

// File: frameStore.sv
`timescale 1ns/1ps

// one-bit-wide frame memory, one pixel per address
// port A reads into an output register, port B loads an image
module frameStore #(
   parameter int ADDR_WIDTH = frameDefs::DEFAULT_ADDR_WIDTH
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  readEnable,    // read issued this cycle
   input  logic [ADDR_WIDTH-1:0] readAddress,
   input  logic                  loadEnable,    // image write strobe
   input  logic [ADDR_WIDTH-1:0] loadAddress,
   input  logic                  loadData,
   output logic                  readData       // valid the cycle after readEnable
);

   localparam int DEPTH = 2 ** ADDR_WIDTH;

   logic pixelMem [0:DEPTH-1];                  // frame contents

   // load port
   // a write lands on the clock edge, a read of the same address
   // in that cycle still sees the old pixel
   always_ff @(posedge clk) begin
      if (loadEnable)
         pixelMem[loadAddress] <= loadData;
   end

   // read port with its output register
   always_ff @(posedge clk) begin
      if (reset)
         readData <= 1'b0;                      // output register back to zero
      else if (readEnable)
         readData <= pixelMem[readAddress];     // holds last pixel when idle
   end

endmodule

// File: frameDefs.sv
package frameDefs;

   // pixel address width, 14 bits gives a 128 x 128 monochrome frame
   // a frame has to hold a whole number of output bytes, so keep this
   // at 3 or more
   localparam int DEFAULT_ADDR_WIDTH = 14;           // 16384 pixels

   // byte credits granted by the downstream side after reset
   localparam int DEFAULT_CREDITS    = 4;

   // complete frames shown before the scanner flips to the other store
   localparam int DEFAULT_FRAME_HOLD = 2;

   // pixels per output byte, fixed by the byte-wide output port
   localparam int PACK_WIDTH         = 8;

   // scanner FSM
   //   scanIdle  : scanEnable low, nothing in flight
   //   scanRun   : issuing the reads of one eight-pixel group
   //   scanStall : scanning requested but no credit left
   typedef enum logic [1:0] {
      scanIdle  = 2'd0,
      scanRun   = 2'd1,
      scanStall = 2'd2
   } scanStateT;

endpackage
